/* flow_scheduler.f */
design/sched_pkg.sv
design/beat_if.sv
design/slot_if.sv
design/payload_fifo.sv
design/slot_pool.sv
design/sched_ctrl.sv
design/hash_prepend.sv
design/flow_scheduler.sv
tests/flow_scheduler_props.sv
tests/tb_flow_scheduler.sv

/* Bender.yml */
package:
  name: flow_scheduler

sources:
  - design/sched_pkg.sv
  - design/beat_if.sv
  - design/slot_if.sv
  - design/payload_fifo.sv
  - design/slot_pool.sv
  - design/sched_ctrl.sv
  - design/hash_prepend.sv
  - design/flow_scheduler.sv
  - target: test
    files:
      - tests/flow_scheduler_props.sv
      - tests/tb_flow_scheduler.sv

/* tests/tb_flow_scheduler.sv */
`default_nettype none

module tb_flow_scheduler;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DRIVE_DELAY = 2;
  localparam int TIMEOUT = 500;
  localparam int IDLE_CYCLES = 40;
  localparam int BEAT_DEPTH = 64;
  localparam int BURST_LEN = 3;

  logic                                                         clk;
  logic                                                         rst_r;
  logic [sched_pkg::PORT_COUNT-1:0][sched_pkg::DATA_WIDTH-1:0]  rx_data;
  logic [sched_pkg::PORT_COUNT-1:0][sched_pkg::KEEP_WIDTH-1:0]  rx_keep;
  logic [sched_pkg::PORT_COUNT-1:0]                             rx_last;
  logic [sched_pkg::PORT_COUNT-1:0]                             rx_valid;
  wire  [sched_pkg::PORT_COUNT-1:0]                             rx_ready;
  logic [sched_pkg::PORT_COUNT-1:0][sched_pkg::HASH_WIDTH-1:0]  hash;
  logic [sched_pkg::PORT_COUNT-1:0]                             hash_valid;
  wire  [sched_pkg::PORT_COUNT-1:0]                             hash_ready;
  logic [sched_pkg::CTRL_WIDTH-1:0]                             ctrl_msg;
  sched_pkg::core_id_t                                          ctrl_src;
  logic                                                         ctrl_valid;
  wire                                                          ctrl_ready;
  logic [sched_pkg::CORE_COUNT-1:0]                             core_enable;
  sched_pkg::core_id_t                                          stat_core;
  wire  [sched_pkg::PORT_COUNT-1:0][sched_pkg::DATA_WIDTH-1:0]  core_data;
  wire  [sched_pkg::PORT_COUNT-1:0][sched_pkg::KEEP_WIDTH-1:0]  core_keep;
  wire  [sched_pkg::PORT_COUNT-1:0]                             core_last;
  wire  [sched_pkg::PORT_COUNT-1:0][sched_pkg::DEST_WIDTH-1:0]  core_dest;
  wire  [sched_pkg::PORT_COUNT-1:0][sched_pkg::PORT_ID_WIDTH-1:0] core_port;
  wire  [sched_pkg::PORT_COUNT-1:0]                             core_valid;
  logic [sched_pkg::PORT_COUNT-1:0]                             core_ready;
  sched_pkg::slot_t                                             slot_count;

  // Expected packet beats per port, written before they are driven
  logic [sched_pkg::DATA_WIDTH-1:0] beat_data [sched_pkg::PORT_COUNT][BEAT_DEPTH];
  logic [sched_pkg::KEEP_WIDTH-1:0] beat_keep [sched_pkg::PORT_COUNT][BEAT_DEPTH];
  logic                             beat_last [sched_pkg::PORT_COUNT][BEAT_DEPTH];
  int                               wr_idx [sched_pkg::PORT_COUNT];
  int                               rd_idx [sched_pkg::PORT_COUNT];
  logic [31:0]                      burst_hash [sched_pkg::PORT_COUNT][BURST_LEN];
  logic [sched_pkg::PORT_COUNT-1:0] random_ready;

  flow_scheduler flow_scheduler_inst (.*);

  always #10 clk = ~clk;

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  always @(flow_scheduler_inst.flow_scheduler_props_inst.fail_count) begin
    assert (flow_scheduler_inst.flow_scheduler_props_inst.fail_count == 0) else
      fail_run("A property in flow_scheduler_props failed");
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    assert (got === expected) else begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
      fail_run("Value check failed");
    end
  endtask

  function automatic logic [31:0] hash_for(input int core);
    logic [31:0] h;
    h = $urandom;
    h[sched_pkg::CORE_ID_WIDTH-1:0] = sched_pkg::core_id_t'(core);
    return h;
  endfunction

  task automatic send_ctrl(input logic [3:0] msg_type, input int src, input int value);
    int cycles;
    @(posedge clk);
    #DRIVE_DELAY;
    ctrl_msg = '0;
    ctrl_msg[sched_pkg::CTRL_WIDTH-1 -: sched_pkg::MSG_TYPE_WIDTH] = msg_type;
    ctrl_msg[sched_pkg::SLOT_FIELD_LSB +: sched_pkg::SLOT_WIDTH] = sched_pkg::slot_t'(value);
    ctrl_src = sched_pkg::core_id_t'(src);
    ctrl_valid = 1'b1;
    cycles = 0;
    @(negedge clk);
    while (!ctrl_ready) begin
      cycles++;
      assert (cycles < TIMEOUT) else fail_run("Timeout waiting for ctrl_ready");
      @(negedge clk);
    end
    @(posedge clk);
    #DRIVE_DELAY;
    ctrl_valid = 1'b0;
  endtask

  // Readback is registered, so the count shows one cycle after the select
  task automatic check_count(input int core, input int expected);
    @(posedge clk);
    #DRIVE_DELAY;
    stat_core = sched_pkg::core_id_t'(core);
    @(posedge clk);
    @(negedge clk);
    check_value($sformatf("slot_count[core %0d]", core), slot_count, expected);
  endtask

  task automatic send_packet(input int p, input logic [31:0] h, input int nbeats);
    int first;
    int cycles;
    first = wr_idx[p];
    for (int i = 0; i < nbeats; i++) begin
      beat_data[p][first+i] = {$urandom, $urandom};
      beat_keep[p][first+i] = (i == nbeats - 1) ? (8'hFF >> ($urandom % 8)) : 8'hFF;
      beat_last[p][first+i] = (i == nbeats - 1);
    end
    wr_idx[p] = first + nbeats;
    @(posedge clk);
    #DRIVE_DELAY;
    hash[p] = h;
    hash_valid[p] = 1'b1;
    cycles = 0;
    @(negedge clk);
    while (!hash_ready[p]) begin
      cycles++;
      assert (cycles < TIMEOUT) else fail_run($sformatf("Timeout on hash_ready[%0d]", p));
      @(negedge clk);
    end
    @(posedge clk);
    #DRIVE_DELAY;
    hash_valid[p] = 1'b0;
    for (int i = 0; i < nbeats; i++) begin
      rx_data[p] = beat_data[p][first+i];
      rx_keep[p] = beat_keep[p][first+i];
      rx_last[p] = beat_last[p][first+i];
      rx_valid[p] = 1'b1;
      cycles = 0;
      @(negedge clk);
      while (!rx_ready[p]) begin
        cycles++;
        assert (cycles < TIMEOUT) else fail_run($sformatf("Timeout on rx_ready[%0d]", p));
        @(negedge clk);
      end
      @(posedge clk);
      #DRIVE_DELAY;
    end
    rx_valid[p] = 1'b0;
  endtask

  // Returns at the falling edge before a transfer, outputs are stable there
  task automatic take_beat(input int p);
    int   cycles;
    logic done;
    cycles = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      #DRIVE_DELAY;
      core_ready[p] = random_ready[p] ? 1'($urandom % 2) : 1'b1;
      @(negedge clk);
      if (core_valid[p] && core_ready[p]) begin
        done = 1'b1;
      end else begin
        cycles++;
        assert (cycles < TIMEOUT) else fail_run($sformatf("Timeout on core_valid[%0d]", p));
      end
    end
  endtask

  task automatic check_beat(input int p, input logic [63:0] data, input logic [7:0] keep,
                            input logic last, input logic [sched_pkg::DEST_WIDTH-1:0] dest);
    check_value($sformatf("core_data[%0d]", p), core_data[p], data);
    check_value($sformatf("core_keep[%0d]", p), core_keep[p], keep);
    check_value($sformatf("core_last[%0d]", p), core_last[p], last);
    check_value($sformatf("core_dest[%0d]", p), core_dest[p], dest);
    check_value($sformatf("core_port[%0d]", p), core_port[p], p);
  endtask

  task automatic receive_packet(input int p, input logic [31:0] h, input int core,
                                input int slot, input int nbeats);
    logic [sched_pkg::DEST_WIDTH-1:0] dest;
    int                               k;
    dest = {sched_pkg::core_id_t'(core), sched_pkg::TAG_WIDTH'(slot)};
    // Header carries the hash in the low word
    take_beat(p);
    check_beat(p, {32'h0, h}, 8'h0F, 1'b0, dest);
    for (int i = 0; i < nbeats; i++) begin
      k = rd_idx[p];
      take_beat(p);
      check_beat(p, beat_data[p][k], beat_keep[p][k], beat_last[p][k], dest);
      rd_idx[p] = k + 1;
    end
    @(posedge clk);
    #DRIVE_DELAY;
    core_ready[p] = 1'b0;
  endtask

  task automatic expect_idle(input int p);
    repeat (IDLE_CYCLES) begin
      @(negedge clk);
      assert (!core_valid[p]) else
        fail_run($sformatf("Port %0d offered a packet that should be held back", p));
    end
  endtask

  task automatic test_after_reset();
    @(negedge clk);
    check_value("rx_ready", rx_ready, {sched_pkg::PORT_COUNT{1'b1}});
    check_value("hash_ready", hash_ready, {sched_pkg::PORT_COUNT{1'b1}});
    check_value("ctrl_ready", ctrl_ready, 1'b1);
    check_value("core_valid", core_valid, '0);
  endtask

  task automatic test_init_counts();
    for (int c = 0; c < sched_pkg::CORE_COUNT; c++) begin
      send_ctrl(sched_pkg::MSG_SLOT_INIT, c, 2 * c + 2);
    end
    for (int c = 0; c < sched_pkg::CORE_COUNT; c++) begin
      check_count(c, 2 * c + 2);
    end
    // Unknown type must leave the pool alone
    send_ctrl(4'd7, 0, 5);
    check_count(0, 2);
    // Core 3 holds all its slots, so a return there is dropped
    send_ctrl(sched_pkg::MSG_SLOT_RETURN, 3, 5);
    check_count(3, 8);
  endtask

  task automatic test_single_packet();
    logic [31:0] h;
    h = hash_for(2);
    fork
      send_packet(0, h, 4);
      receive_packet(0, h, 2, 1, 4);
    join
    check_count(2, 5);
  endtask

  task automatic test_slot_return();
    logic [31:0] h_first;
    logic [31:0] h_second;
    h_first = hash_for(3);
    h_second = hash_for(3);
    send_ctrl(sched_pkg::MSG_SLOT_INIT, 3, 1);
    fork
      send_packet(0, h_first, 3);
      receive_packet(0, h_first, 3, 1, 3);
    join
    send_packet(0, h_second, 2);
    expect_idle(0);
    send_ctrl(sched_pkg::MSG_SLOT_RETURN, 3, 5);
    receive_packet(0, h_second, 3, 5, 2);
    check_count(3, 0);
  endtask

  task automatic test_core_enable();
    logic [31:0] h;
    h = hash_for(1);
    @(posedge clk);
    #DRIVE_DELAY;
    core_enable[1] = 1'b0;
    send_packet(1, h, 3);
    expect_idle(1);
    @(posedge clk);
    #DRIVE_DELAY;
    core_enable[1] = 1'b1;
    receive_packet(1, h, 1, 1, 3);
    check_count(1, 3);
  endtask

  task automatic send_burst(input int p);
    for (int k = 0; k < BURST_LEN; k++) begin
      send_packet(p, burst_hash[p][k], k + 2);
    end
  endtask

  // Port p feeds core p, so slots come out as 1, 2, 3
  task automatic receive_burst(input int p);
    for (int k = 0; k < BURST_LEN; k++) begin
      receive_packet(p, burst_hash[p][k], p, k + 1, k + 2);
    end
  endtask

  task automatic test_two_ports();
    send_ctrl(sched_pkg::MSG_SLOT_INIT, 0, 8);
    send_ctrl(sched_pkg::MSG_SLOT_INIT, 1, 8);
    for (int k = 0; k < BURST_LEN; k++) begin
      burst_hash[0][k] = hash_for(0);
      burst_hash[1][k] = hash_for(1);
    end
    random_ready = '1;
    fork
      send_burst(0);
      send_burst(1);
      receive_burst(0);
      receive_burst(1);
    join
    random_ready = '0;
    check_count(0, 8 - BURST_LEN);
    check_count(1, 8 - BURST_LEN);
  endtask

  initial begin
    void'($urandom(32'h174cca59));
    clk = 1'b0;
    rst_r = 1'b1;
    rx_data = '0;
    rx_keep = '0;
    rx_last = '0;
    rx_valid = '0;
    hash = '0;
    hash_valid = '0;
    ctrl_msg = '0;
    ctrl_src = '0;
    ctrl_valid = 1'b0;
    core_enable = '1;
    stat_core = '0;
    core_ready = '0;
    random_ready = '0;
    for (int p = 0; p < sched_pkg::PORT_COUNT; p++) begin
      wr_idx[p] = 0;
      rd_idx[p] = 0;
    end
    repeat (4) @(posedge clk);
    #DRIVE_DELAY;
    rst_r = 1'b0;

    test_after_reset();
    test_init_counts();
    test_single_packet();
    test_slot_return();
    test_core_enable();
    test_two_ports();

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/flow_scheduler_props.sv */
`default_nettype none

module flow_scheduler_props (
  input wire                                                         clk,
  input wire                                                         rst_r,
  input wire [sched_pkg::PORT_COUNT-1:0][sched_pkg::DATA_WIDTH-1:0]  core_data,
  input wire [sched_pkg::PORT_COUNT-1:0][sched_pkg::KEEP_WIDTH-1:0]  core_keep,
  input wire [sched_pkg::PORT_COUNT-1:0]                             core_last,
  input wire [sched_pkg::PORT_COUNT-1:0][sched_pkg::DEST_WIDTH-1:0]  core_dest,
  input wire [sched_pkg::PORT_COUNT-1:0][sched_pkg::PORT_ID_WIDTH-1:0] core_port,
  input wire [sched_pkg::PORT_COUNT-1:0]                             core_valid,
  input wire [sched_pkg::PORT_COUNT-1:0]                             core_ready,
  input wire sched_pkg::slot_t                                       slot_count
);

  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  for (genvar p = 0; p < sched_pkg::PORT_COUNT; p++) begin : g_port
    // A stalled beat keeps its payload and tags until it is taken
    stall_hold: assert property (@(posedge clk) disable iff (rst_r)
      core_valid[p] && !core_ready[p] |=>
        core_valid[p] && $stable(core_data[p]) && $stable(core_keep[p]) &&
        $stable(core_last[p]) && $stable(core_dest[p]) && $stable(core_port[p]))
      else begin
        $error("port %0d changed a stalled core beat", p);
        fail_count++;
      end
  end

  reset_idle: assert property (@(posedge clk) rst_r |=> core_valid == '0)
    else begin
      $error("core_valid high right after reset");
      fail_count++;
    end

  count_bound: assert property (@(posedge clk) disable iff (rst_r)
    slot_count <= sched_pkg::SLOT_COUNT)
    else begin
      $error("slot_count %0d above pool size", slot_count);
      fail_count++;
    end

endmodule

bind flow_scheduler flow_scheduler_props flow_scheduler_props_inst (
  .clk        (clk),
  .rst_r      (rst_r),
  .core_data  (core_data),
  .core_keep  (core_keep),
  .core_last  (core_last),
  .core_dest  (core_dest),
  .core_port  (core_port),
  .core_valid (core_valid),
  .core_ready (core_ready),
  .slot_count (slot_count)
);

`default_nettype wire

/* design/flow_scheduler.sv */
`default_nettype none

module flow_scheduler (
  input  wire                                                         clk,
  input  wire                                                         rst_r,

  input  wire  [sched_pkg::PORT_COUNT-1:0][sched_pkg::DATA_WIDTH-1:0] rx_data,
  input  wire  [sched_pkg::PORT_COUNT-1:0][sched_pkg::KEEP_WIDTH-1:0] rx_keep,
  input  wire  [sched_pkg::PORT_COUNT-1:0]                            rx_last,
  input  wire  [sched_pkg::PORT_COUNT-1:0]                            rx_valid,
  output wire  [sched_pkg::PORT_COUNT-1:0]                            rx_ready,

  input  wire  [sched_pkg::PORT_COUNT-1:0][sched_pkg::HASH_WIDTH-1:0] hash,
  input  wire  [sched_pkg::PORT_COUNT-1:0]                            hash_valid,
  output wire  [sched_pkg::PORT_COUNT-1:0]                            hash_ready,

  input  wire  [sched_pkg::CTRL_WIDTH-1:0]                            ctrl_msg,
  input  wire  sched_pkg::core_id_t                                   ctrl_src,
  input  wire                                                         ctrl_valid,
  output wire                                                         ctrl_ready,

  input  wire  [sched_pkg::CORE_COUNT-1:0]                            core_enable,
  input  wire  sched_pkg::core_id_t                                   stat_core,

  output wire  [sched_pkg::PORT_COUNT-1:0][sched_pkg::DATA_WIDTH-1:0] core_data,
  output wire  [sched_pkg::PORT_COUNT-1:0][sched_pkg::KEEP_WIDTH-1:0] core_keep,
  output wire  [sched_pkg::PORT_COUNT-1:0]                            core_last,
  output wire  [sched_pkg::PORT_COUNT-1:0][sched_pkg::DEST_WIDTH-1:0] core_dest,
  output wire  [sched_pkg::PORT_COUNT-1:0][sched_pkg::PORT_ID_WIDTH-1:0] core_port,
  output wire  [sched_pkg::PORT_COUNT-1:0]                            core_valid,
  input  wire  [sched_pkg::PORT_COUNT-1:0]                            core_ready,

  output sched_pkg::slot_t                                            slot_count
);

  logic [sched_pkg::PORT_COUNT-1:0][sched_pkg::HASH_WIDTH-1:0] fifo_hash;
  logic [sched_pkg::PORT_COUNT-1:0]                            fifo_hash_valid;
  logic [sched_pkg::PORT_COUNT-1:0]                            fifo_hash_pop;
  sched_pkg::desc_t [sched_pkg::PORT_COUNT-1:0]                new_desc;
  logic [sched_pkg::PORT_COUNT-1:0]                            new_desc_push;
  logic [sched_pkg::PORT_COUNT-1:0]                            new_desc_ready;
  sched_pkg::slot_t [sched_pkg::CORE_COUNT-1:0]                core_counts;

  slot_if pool_if [sched_pkg::CORE_COUNT] ();

  for (genvar p = 0; p < sched_pkg::PORT_COUNT; p++) begin : g_port
    sched_pkg::beat_t rx_beat;
    sched_pkg::beat_t pkt_beat;
    sched_pkg::desc_t head_desc;
    logic             head_desc_valid;
    logic             head_desc_pop;

    beat_if pkt_if ();

    assign rx_beat = '{data: rx_data[p], keep: rx_keep[p], last: rx_last[p]};

    payload_fifo #(
      .T     (sched_pkg::beat_t),
      .DEPTH (sched_pkg::DATA_FIFO_DEPTH)
    ) data_fifo_inst (
      .clk       (clk),
      .rst_r     (rst_r),
      .in_data   (rx_beat),
      .in_valid  (rx_valid[p]),
      .in_ready  (rx_ready[p]),
      .out_data  (pkt_beat),
      .out_valid (pkt_if.valid),
      .out_ready (pkt_if.ready)
    );

    assign pkt_if.data = pkt_beat.data;
    assign pkt_if.keep = pkt_beat.keep;
    assign pkt_if.last = pkt_beat.last;

    // One hash per packet, deep enough to match the data FIFO
    payload_fifo #(
      .T     (logic [sched_pkg::HASH_WIDTH-1:0]),
      .DEPTH (sched_pkg::DATA_FIFO_DEPTH)
    ) hash_fifo_inst (
      .clk       (clk),
      .rst_r     (rst_r),
      .in_data   (hash[p]),
      .in_valid  (hash_valid[p]),
      .in_ready  (hash_ready[p]),
      .out_data  (fifo_hash[p]),
      .out_valid (fifo_hash_valid[p]),
      .out_ready (fifo_hash_pop[p])
    );

    payload_fifo #(
      .T     (sched_pkg::desc_t),
      .DEPTH (sched_pkg::DESC_FIFO_DEPTH)
    ) desc_fifo_inst (
      .clk       (clk),
      .rst_r     (rst_r),
      .in_data   (new_desc[p]),
      .in_valid  (new_desc_push[p]),
      .in_ready  (new_desc_ready[p]),
      .out_data  (head_desc),
      .out_valid (head_desc_valid),
      .out_ready (head_desc_pop)
    );

    hash_prepend #(
      .PORT_ID (p)
    ) hash_prepend_inst (
      .clk        (clk),
      .rst_r      (rst_r),
      .desc       (head_desc),
      .desc_valid (head_desc_valid),
      .desc_pop   (head_desc_pop),
      .pkt        (pkt_if),
      .core_data  (core_data[p]),
      .core_keep  (core_keep[p]),
      .core_last  (core_last[p]),
      .core_dest  (core_dest[p]),
      .core_port  (core_port[p]),
      .core_valid (core_valid[p]),
      .core_ready (core_ready[p])
    );
  end

  for (genvar c = 0; c < sched_pkg::CORE_COUNT; c++) begin : g_core
    slot_pool slot_pool_inst (
      .clk   (clk),
      .rst_r (rst_r),
      .pool  (pool_if[c])
    );

    assign core_counts[c] = pool_if[c].count;
  end

  sched_ctrl sched_ctrl_inst (
    .clk         (clk),
    .rst_r       (rst_r),
    .ctrl_msg    (ctrl_msg),
    .ctrl_src    (ctrl_src),
    .ctrl_valid  (ctrl_valid),
    .ctrl_ready  (ctrl_ready),
    .core_enable (core_enable),
    .hash_in     (fifo_hash),
    .hash_valid  (fifo_hash_valid),
    .hash_pop    (fifo_hash_pop),
    .desc_out    (new_desc),
    .desc_push   (new_desc_push),
    .desc_ready  (new_desc_ready),
    .pools       (pool_if)
  );

  // Host readback of one core's free slots
  always_ff @(posedge clk) begin
    if (rst_r) begin
      slot_count <= '0;
    end else begin
      slot_count <= core_counts[stat_core];
    end
  end

endmodule

`default_nettype wire

/* design/hash_prepend.sv */
`default_nettype none

module hash_prepend #(
  parameter int PORT_ID = 0
) (
  input  wire                                  clk,
  input  wire                                  rst_r,

  input  wire  sched_pkg::desc_t               desc,
  input  wire                                  desc_valid,
  output logic                                 desc_pop,

  beat_if.dst                                  pkt,

  output logic [sched_pkg::DATA_WIDTH-1:0]     core_data,
  output logic [sched_pkg::KEEP_WIDTH-1:0]     core_keep,
  output logic                                 core_last,
  output logic [sched_pkg::DEST_WIDTH-1:0]     core_dest,
  output logic [sched_pkg::PORT_ID_WIDTH-1:0]  core_port,
  output logic                                 core_valid,
  input  wire                                  core_ready
);

  typedef enum logic {
    ST_HEADER,
    ST_BODY
  } state_t;

  state_t state;
  logic   in_header;
  logic   body_end;

  assign in_header = (state == ST_HEADER);
  assign body_end  = !in_header && pkt.valid && core_ready && pkt.last;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      state <= ST_HEADER;
    end else begin
      case (state)
        ST_HEADER: begin
          if (desc_valid && core_ready) begin
            state <= ST_BODY;
          end
        end
        ST_BODY: begin
          if (body_end) begin
            state <= ST_HEADER;
          end
        end
        default: state <= ST_HEADER;
      endcase
    end
  end

  // Header beat holds the hash in the low word
  assign core_data  = in_header ?
                      {{(sched_pkg::DATA_WIDTH - sched_pkg::HASH_WIDTH){1'b0}}, desc.hash} :
                      pkt.data;
  assign core_keep  = in_header ? sched_pkg::KEEP_WIDTH'(8'h0F) : pkt.keep;
  assign core_last  = in_header ? 1'b0 : pkt.last;
  assign core_valid = in_header ? desc_valid : pkt.valid;

  // Descriptor stays at the FIFO head until the last beat leaves
  assign core_dest = desc.dest;
  assign core_port = sched_pkg::PORT_ID_WIDTH'(PORT_ID);

  assign pkt.ready = !in_header && core_ready;
  assign desc_pop  = body_end;

endmodule

`default_nettype wire

/* design/sched_ctrl.sv */
`default_nettype none

module sched_ctrl (
  input  wire                                             clk,
  input  wire                                             rst_r,

  input  wire  [sched_pkg::CTRL_WIDTH-1:0]                ctrl_msg,
  input  wire  sched_pkg::core_id_t                       ctrl_src,
  input  wire                                             ctrl_valid,
  output logic                                            ctrl_ready,

  input  wire  [sched_pkg::CORE_COUNT-1:0]                core_enable,

  input  wire  [sched_pkg::PORT_COUNT-1:0][sched_pkg::HASH_WIDTH-1:0] hash_in,
  input  wire  [sched_pkg::PORT_COUNT-1:0]                hash_valid,
  output logic [sched_pkg::PORT_COUNT-1:0]                hash_pop,

  output sched_pkg::desc_t [sched_pkg::PORT_COUNT-1:0]    desc_out,
  output logic [sched_pkg::PORT_COUNT-1:0]                desc_push,
  input  wire  [sched_pkg::PORT_COUNT-1:0]                desc_ready,

  slot_if.ctrl                                            pools [sched_pkg::CORE_COUNT]
);

  logic [sched_pkg::MSG_TYPE_WIDTH-1:0]            msg_type;
  sched_pkg::slot_t                                msg_slot;
  sched_pkg::slot_t [sched_pkg::CORE_COUNT-1:0]    head_slot;
  logic [sched_pkg::CORE_COUNT-1:0]                head_valid;

  logic [sched_pkg::PORT_COUNT-1:0]                req;
  logic [sched_pkg::PORT_ID_WIDTH-1:0]             rr_ptr;
  logic [sched_pkg::PORT_ID_WIDTH-1:0]             grant;
  logic                                            grant_valid;
  sched_pkg::core_id_t                             target;
  logic                                            alloc;
  sched_pkg::desc_t                                alloc_desc;

  // Every message is taken at once, unknown types are dropped
  assign ctrl_ready = 1'b1;
  assign msg_type   = ctrl_msg[sched_pkg::CTRL_WIDTH-1 -: sched_pkg::MSG_TYPE_WIDTH];
  assign msg_slot   = ctrl_msg[sched_pkg::SLOT_FIELD_LSB +: sched_pkg::SLOT_WIDTH];

  for (genvar c = 0; c < sched_pkg::CORE_COUNT; c++) begin : g_pool
    assign pools[c].init       = ctrl_valid && (msg_type == sched_pkg::MSG_SLOT_INIT) &&
                                 (ctrl_src == sched_pkg::core_id_t'(c));
    assign pools[c].init_count = msg_slot;
    assign pools[c].ret        = ctrl_valid && (msg_type == sched_pkg::MSG_SLOT_RETURN) &&
                                 (ctrl_src == sched_pkg::core_id_t'(c));
    assign pools[c].ret_slot   = msg_slot;
    assign pools[c].pop        = alloc && (target == sched_pkg::core_id_t'(c));
    assign head_slot[c]        = pools[c].head;
    assign head_valid[c]       = pools[c].head_valid;
  end

  // A port competes only if it has a hash and room for a descriptor
  assign req = hash_valid & desc_ready;

  always_comb begin
    int idx;
    grant_valid = 1'b0;
    grant       = '0;
    for (int k = 0; k < sched_pkg::PORT_COUNT; k++) begin
      idx = (int'(rr_ptr) + k) % sched_pkg::PORT_COUNT;
      if (!grant_valid && req[idx]) begin
        grant_valid = 1'b1;
        grant       = sched_pkg::PORT_ID_WIDTH'(idx);
      end
    end
  end

  // Pointer moves on every grant so a stuck port cannot starve the others
  always_ff @(posedge clk) begin
    if (rst_r) begin
      rr_ptr <= '0;
    end else if (grant_valid) begin
      rr_ptr <= (grant == sched_pkg::PORT_ID_WIDTH'(sched_pkg::PORT_COUNT - 1)) ?
                '0 : grant + 1'b1;
    end
  end

  assign target = hash_in[grant][sched_pkg::CORE_ID_WIDTH-1:0];
  assign alloc  = grant_valid && core_enable[target] && head_valid[target];

  assign alloc_desc.hash = hash_in[grant];
  assign alloc_desc.dest = {target, sched_pkg::TAG_WIDTH'(head_slot[target])};

  for (genvar p = 0; p < sched_pkg::PORT_COUNT; p++) begin : g_port
    assign hash_pop[p]  = alloc && (grant == sched_pkg::PORT_ID_WIDTH'(p));
    assign desc_push[p] = alloc && (grant == sched_pkg::PORT_ID_WIDTH'(p));
    assign desc_out[p]  = alloc_desc;
  end

endmodule

`default_nettype wire

/* design/slot_pool.sv */
`default_nettype none

module slot_pool (
  input wire   clk,
  input wire   rst_r,
  slot_if.pool pool
);

  typedef logic [$clog2(sched_pkg::SLOT_COUNT)-1:0] ptr_t;

  sched_pkg::slot_t mem [sched_pkg::SLOT_COUNT];
  ptr_t             rd_ptr;
  ptr_t             wr_ptr;
  sched_pkg::slot_t count;
  sched_pkg::slot_t load_count;
  logic             full;
  logic             ret_ok;
  logic             pop_ok;

  function automatic ptr_t next_ptr(ptr_t p);
    return (p == ptr_t'(sched_pkg::SLOT_COUNT - 1)) ? '0 : p + 1'b1;
  endfunction

  // Init counts beyond the queue size are clamped
  assign load_count = (pool.init_count > sched_pkg::slot_t'(sched_pkg::SLOT_COUNT)) ?
                      sched_pkg::slot_t'(sched_pkg::SLOT_COUNT) : pool.init_count;

  assign full   = (count == sched_pkg::slot_t'(sched_pkg::SLOT_COUNT));
  assign ret_ok = pool.ret && !full;
  assign pop_ok = pool.pop && (count != '0);

  assign pool.head       = mem[rd_ptr];
  assign pool.head_valid = (count != '0);
  assign pool.count      = count;

  // Init writes 1..SLOT_COUNT, only the first load_count entries are live
  always_ff @(posedge clk) begin
    if (pool.init) begin
      for (int i = 0; i < sched_pkg::SLOT_COUNT; i++) begin
        mem[i] <= sched_pkg::slot_t'(i + 1);
      end
    end else if (ret_ok) begin
      mem[wr_ptr] <= pool.ret_slot;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (pool.init) begin
      rd_ptr <= '0;
      wr_ptr <= (load_count == sched_pkg::slot_t'(sched_pkg::SLOT_COUNT)) ?
                '0 : ptr_t'(load_count);
      count  <= load_count;
    end else begin
      if (ret_ok) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop_ok) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + sched_pkg::slot_t'(ret_ok) - sched_pkg::slot_t'(pop_ok);
    end
  end

endmodule

`default_nettype wire

/* design/payload_fifo.sv */
`default_nettype none

module payload_fifo #(
  parameter type T = logic,
  parameter int DEPTH = 4
) (
  input  wire  clk,
  input  wire  rst_r,

  input  wire  T in_data,
  input  wire  in_valid,
  output logic in_ready,

  output T     out_data,
  output logic out_valid,
  input  wire  out_ready
);

  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T                   mem [DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [PTR_WIDTH:0]   fill;
  logic                 do_wr;
  logic                 do_rd;

  assign in_ready  = (fill != (PTR_WIDTH+1)'(DEPTH));
  assign out_valid = (fill != '0);
  assign out_data  = mem[rd_ptr];

  assign do_wr = in_valid && in_ready;
  assign do_rd = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      fill <= fill + (PTR_WIDTH+1)'(do_wr) - (PTR_WIDTH+1)'(do_rd);
    end
  end

endmodule

`default_nettype wire

/* design/slot_if.sv */
`default_nettype none

interface slot_if;

  // Requests from the controller
  logic              init;
  sched_pkg::slot_t  init_count;
  logic              ret;
  sched_pkg::slot_t  ret_slot;
  logic              pop;

  // Pool state
  sched_pkg::slot_t  head;
  logic              head_valid;
  sched_pkg::slot_t  count;

  modport ctrl (
    output init, init_count, ret, ret_slot, pop,
    input  head, head_valid, count
  );

  modport pool (
    input  init, init_count, ret, ret_slot, pop,
    output head, head_valid, count
  );

endinterface

`default_nettype wire

/* design/beat_if.sv */
`default_nettype none

interface beat_if;

  logic [sched_pkg::DATA_WIDTH-1:0] data;
  logic [sched_pkg::KEEP_WIDTH-1:0] keep;
  logic                             last;
  logic                             valid;
  logic                             ready;

  modport src (
    output data, keep, last, valid,
    input  ready
  );

  modport dst (
    input  data, keep, last, valid,
    output ready
  );

endinterface

`default_nettype wire

/* design/sched_pkg.sv */
`default_nettype none

package sched_pkg;

  localparam int PORT_COUNT = 2;
  localparam int PORT_ID_WIDTH = (PORT_COUNT > 1) ? $clog2(PORT_COUNT) : 1;
  localparam int CORE_COUNT = 4;
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT);
  localparam int SLOT_COUNT = 8;
  localparam int SLOT_WIDTH = $clog2(SLOT_COUNT + 1);
  localparam int TAG_WIDTH = (SLOT_WIDTH > 5) ? SLOT_WIDTH : 5;
  localparam int DEST_WIDTH = CORE_ID_WIDTH + TAG_WIDTH;
  localparam int DATA_WIDTH = 64;
  localparam int KEEP_WIDTH = DATA_WIDTH / 8;
  localparam int HASH_WIDTH = 32;

  // Control word: type in the top nibble, slot or count at SLOT_FIELD_LSB
  localparam int MSG_TYPE_WIDTH = 4;
  localparam int CTRL_WIDTH = 36;
  localparam logic [MSG_TYPE_WIDTH-1:0] MSG_SLOT_RETURN = 4'd0;
  localparam logic [MSG_TYPE_WIDTH-1:0] MSG_SLOT_INIT = 4'd3;
  localparam int SLOT_FIELD_LSB = 16;

  localparam int DATA_FIFO_DEPTH = 64;
  localparam int DESC_FIFO_DEPTH = 4;

  typedef logic [CORE_ID_WIDTH-1:0] core_id_t;
  typedef logic [SLOT_WIDTH-1:0] slot_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [KEEP_WIDTH-1:0] keep;
    logic                  last;
  } beat_t;

  // dest is the core number above the zero-padded slot tag
  typedef struct packed {
    logic [HASH_WIDTH-1:0] hash;
    logic [DEST_WIDTH-1:0] dest;
  } desc_t;

endpackage

`default_nettype wire
